// File: src/hub75Pkg.sv
/*
 * shared panel sizes, FM6126 configuration words and init FSM encodings
 * packed structs for pixels, frame buffer addresses and the HUB75 bus
 */
package hub75Pkg;

    // 64x32 panel, scanned as 16 row pairs (rows r and r+16 shift together)
    localparam int PANEL_WIDTH = 64;
    localparam int ROW_PAIRS = 16;

    // FM6126 configuration words and the number of latched columns per write
    localparam logic [15:0] INIT_REG12_WORD = 16'h7FFF;
    localparam logic [15:0] INIT_REG13_WORD = 16'h0040;
    localparam int REG12_LATCH_COLUMNS = 12;
    localparam int REG13_LATCH_COLUMNS = 13;

    // one-hot init states, ordered so that each step forward is a left shift
    localparam logic [5:0] INIT_REG12_BEGIN = 6'b000001;
    localparam logic [5:0] INIT_REG12_END = 6'b000010;
    localparam logic [5:0] INIT_REG13_BEGIN = 6'b000100;
    localparam logic [5:0] INIT_REG13_END = 6'b001000;
    localparam logic [5:0] INIT_FINISH = 6'b010000;
    localparam logic [5:0] INIT_FORWARD = 6'b100000;

    typedef struct packed {logic red; logic green; logic blue;} rgb_t;

    // top drives the upper half of the panel, bottom the lower half
    typedef struct packed {rgb_t top; rgb_t bottom;} pixelPair_t;

    typedef struct packed {logic [3:0] rowPair; logic [5:0] column;} pixelAddr_t;

    typedef struct packed {pixelAddr_t addr; pixelPair_t data;} pixelWrite_t;

    // blank high turns the LEDs off
    typedef struct packed {
        rgb_t       rgb1;
        rgb_t       rgb2;
        logic       latch;
        logic       blank;
        logic       pixClock;
        logic [3:0] rowAddr;
    } hub75Bus_t;

    // quiet bus with the LEDs off, used after reset and between phases
    localparam hub75Bus_t BUS_BLANKED = '{rgb1: '0, rgb2: '0, latch: 1'b0, blank: 1'b1,
                                          pixClock: 1'b0, rowAddr: 4'd0};

endpackage

// File: src/frameBuffer.sv
/*
 * frame buffer with one pixel pair per row pair and column
 * single write port and a registered read port
 */
`timescale 1ns/1ns

module frameBuffer (
    input  logic                  clk_in,
    input  hub75Pkg::pixelWrite_t pixelWrite,
    input  logic                  pixelWriteStrobe,
    input  hub75Pkg::pixelAddr_t  readAddr,
    output hub75Pkg::pixelPair_t  readData
);

    // 16 row pairs of 64 columns make 1024 entries in all
    hub75Pkg::pixelPair_t pixelMem [hub75Pkg::ROW_PAIRS * hub75Pkg::PANEL_WIDTH];

    logic [$bits(hub75Pkg::pixelAddr_t)-1:0] writeIndex;
    logic [$bits(hub75Pkg::pixelAddr_t)-1:0] readIndex;

    // the row pair sits in the upper bits so each row pair is one contiguous block
    assign writeIndex = {pixelWrite.addr.rowPair, pixelWrite.addr.column};
    assign readIndex = {readAddr.rowPair, readAddr.column};

    // the pair is stored on the clock edge where the strobe is high
    always_ff @(posedge clk_in) begin
        if (pixelWriteStrobe) begin
            pixelMem[writeIndex] <= pixelWrite.data;
        end
    end

    // the read is registered and its data is valid one cycle after the address
    // a read and a write to the same entry in one cycle return the old pair
    always_ff @(posedge clk_in) begin
        readData <= pixelMem[readIndex];
    end

endmodule

// File: src/scanDriver.sv
/*
 * HUB75 scan driver that shifts one row pair at a time out of the frame buffer
 * then blanks, latches and selects the row pair in a four-cycle gap
 */
`timescale 1ns/1ns

module scanDriver (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 initDone,
    output hub75Pkg::pixelAddr_t readAddr,
    input  hub75Pkg::pixelPair_t readData,
    output hub75Pkg::hub75Bus_t  scanBus
);

    logic [5:0] column;
    logic [3:0] rowPair;
    logic [3:0] nextRowPair;
    // set when the next edge drives pixClock high
    logic       highPhase;
    logic       inGap;
    logic [1:0] gapStep;
    logic       lastColumn;

    assign nextRowPair = (rowPair == 4'(hub75Pkg::ROW_PAIRS - 1)) ? 4'd0 : rowPair + 4'd1;
    assign lastColumn = (column == 6'(hub75Pkg::PANEL_WIDTH - 1));

    // a row pair takes 64 columns of two cycles and a four-cycle gap, 132 cycles
    // readAddr always points one column ahead of the column on the bus, so the
    // registered read has the next pair ready by the following low phase
    always_ff @(posedge clk_in) begin
        if (reset) begin
            column <= '0;
            rowPair <= '0;
            highPhase <= 1'b0;
            inGap <= 1'b0;
            gapStep <= '0;
            // row pair 0 column 0 is read continuously while idle
            readAddr <= '0;
            scanBus <= hub75Pkg::BUS_BLANKED;
        end else if (initDone) begin
            if (inGap) begin
                case (gapStep)
                    2'd0: begin
                        // clock low with the LEDs off, and fetch column 0 of the
                        // next row pair while the gap runs
                        scanBus.pixClock <= 1'b0;
                        scanBus.blank <= 1'b1;
                        readAddr <= '{rowPair: nextRowPair, column: 6'd0};
                    end
                    2'd1: begin
                        scanBus.latch <= 1'b1;
                    end
                    2'd2: begin
                        // the latched data belongs to the row pair just shifted
                        scanBus.latch <= 1'b0;
                        scanBus.rowAddr <= rowPair;
                        rowPair <= nextRowPair;
                    end
                    default: begin
                        scanBus.blank <= 1'b0;
                        inGap <= 1'b0;
                    end
                endcase
                gapStep <= gapStep + 2'd1;
            end else if (!highPhase) begin
                // low phase puts the pair fetched one column early on the bus
                scanBus.pixClock <= 1'b0;
                scanBus.blank <= 1'b0;
                scanBus.rgb1 <= readData.top;
                scanBus.rgb2 <= readData.bottom;
                readAddr.column <= column + 6'd1;
                highPhase <= 1'b1;
            end else begin
                // high phase, the panel samples the colour lines here
                scanBus.pixClock <= 1'b1;
                highPhase <= 1'b0;
                if (lastColumn) begin
                    column <= '0;
                    inGap <= 1'b1;
                end else begin
                    column <= column + 6'd1;
                end
            end
        end
    end

endmodule

// File: src/panelInitSequencer.sv
/*
 * FM6126 init FSM that writes configuration registers 12 and 13
 * and then forwards the scan driver bus to the panel port
 */
`timescale 1ns/1ns

module panelInitSequencer (
    input  logic                clk_in,
    input  logic                reset,
    input  hub75Pkg::hub75Bus_t scanBus,
    output hub75Pkg::hub75Bus_t panelBus,
    output logic                initDone
);

    // one bit per column, shifted down once per column
    // latch is raised once the remaining ones have all dropped out
    logic [hub75Pkg::PANEL_WIDTH-1:0] latchMask;
    logic [5:0]                       columnCount;
    logic [5:0]                       initState;
    logic [15:0]                      regWord;
    logic                             dataBit;
    logic                             lastColumn;

    // register 13 is written in the second pair of states, register 12 in the first
    assign regWord = (initState == hub75Pkg::INIT_REG13_BEGIN ||
                      initState == hub75Pkg::INIT_REG13_END) ?
                     hub75Pkg::INIT_REG13_WORD : hub75Pkg::INIT_REG12_WORD;

    // the low four bits of the column count are the column modulo 16
    assign dataBit = regWord[columnCount[3:0]];

    assign lastColumn = (columnCount == 6'(hub75Pkg::PANEL_WIDTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            initState <= hub75Pkg::INIT_REG12_BEGIN;
            columnCount <= '0;
            // 52 ones, so the mask empties for the last 12 columns
            latchMask <= {hub75Pkg::PANEL_WIDTH{1'b1}} >> hub75Pkg::REG12_LATCH_COLUMNS;
            initDone <= 1'b0;
            panelBus <= hub75Pkg::BUS_BLANKED;
        end else begin
            case (initState)
                hub75Pkg::INIT_REG12_BEGIN, hub75Pkg::INIT_REG13_BEGIN: begin
                    // clock low with the new column's bit on all six colour lines
                    panelBus.rgb1 <= {3{dataBit}};
                    panelBus.rgb2 <= {3{dataBit}};
                    panelBus.latch <= ~(|latchMask);
                    panelBus.pixClock <= 1'b0;
                    initState <= initState << 1;
                end
                hub75Pkg::INIT_REG12_END, hub75Pkg::INIT_REG13_END: begin
                    // rising edge, data and latch stay as set in the begin state
                    panelBus.pixClock <= 1'b1;
                    if (lastColumn) begin
                        // move on to register 13, or to the finish state after it
                        initState <= initState << 1;
                        columnCount <= '0;
                        latchMask <= {hub75Pkg::PANEL_WIDTH{1'b1}} >>
                                     hub75Pkg::REG13_LATCH_COLUMNS;
                    end else begin
                        // back to the begin state of the same register
                        initState <= initState >> 1;
                        columnCount <= columnCount + 6'd1;
                        latchMask <= latchMask >> 1;
                    end
                end
                hub75Pkg::INIT_FINISH: begin
                    // drop latch and clock, then let the scan driver start
                    panelBus <= hub75Pkg::BUS_BLANKED;
                    initDone <= 1'b1;
                    initState <= hub75Pkg::INIT_FORWARD;
                end
                hub75Pkg::INIT_FORWARD: begin
                    // one register stage between the scan driver and the panel
                    panelBus <= scanBus;
                end
                default: begin
                    initState <= hub75Pkg::INIT_REG12_BEGIN;
                end
            endcase
        end
    end

endmodule

// File: src/hub75Top.sv
/*
 * top level of the 64x32 HUB75 panel driver
 * frame buffer, scan driver and FM6126 init sequencer
 */
`timescale 1ns/1ns

module hub75Top (
    input  logic                  clk_in,
    input  logic                  reset,
    input  hub75Pkg::pixelWrite_t pixelWrite,
    input  logic                  pixelWriteStrobe,
    output hub75Pkg::hub75Bus_t   panelBus
);

    // frame buffer read port, driven by the scan driver
    hub75Pkg::pixelAddr_t readAddr;
    hub75Pkg::pixelPair_t readData;

    // scan driver bus, forwarded to the panel once init has finished
    hub75Pkg::hub75Bus_t  scanBus;
    logic                 initDone;

    // pixel writes are accepted at any time, including during init
    frameBuffer u_frameBuffer (
        .clk_in          (clk_in),
        .pixelWrite      (pixelWrite),
        .pixelWriteStrobe(pixelWriteStrobe),
        .readAddr        (readAddr),
        .readData        (readData)
    );

    // held idle until the init sequencer raises initDone
    scanDriver u_scanDriver (
        .clk_in  (clk_in),
        .reset   (reset),
        .initDone(initDone),
        .readAddr(readAddr),
        .readData(readData),
        .scanBus (scanBus)
    );

    panelInitSequencer u_panelInitSequencer (
        .clk_in  (clk_in),
        .reset   (reset),
        .scanBus (scanBus),
        .panelBus(panelBus),
        .initDone(initDone)
    );

endmodule

// File: tests/hub75Tb.sv
/*
 * testbench for the HUB75 panel driver with FM6126 init
 * writes one frame from a table of row colours, then checks init and two scanned frames
 */
`timescale 1ns/1ns

module hub75Tb;

    localparam int INIT_EDGES = 2 * hub75Pkg::PANEL_WIDTH;
    localparam int ROW_CYCLES = 132;
    localparam int FRAMES = 2;
    localparam int ROWS_TO_CHECK = FRAMES * hub75Pkg::ROW_PAIRS;
    localparam int PIXELS = hub75Pkg::ROW_PAIRS * hub75Pkg::PANEL_WIDTH;
    // init, two full frames and some slack
    localparam int CYCLE_LIMIT = 300 + FRAMES * hub75Pkg::ROW_PAIRS * ROW_CYCLES + 500;

    // base colours per row pair, written in octal as top then bottom
    localparam hub75Pkg::pixelPair_t ROW_BASE [hub75Pkg::ROW_PAIRS] = '{
        6'o70, 6'o07, 6'o12, 6'o21, 6'o34, 6'o43, 6'o56, 6'o65,
        6'o77, 6'o00, 6'o14, 6'o41, 6'o25, 6'o52, 6'o36, 6'o63
    };

    logic                  clk_in;
    logic                  reset;
    hub75Pkg::pixelWrite_t pixelWrite;
    logic                  pixelWriteStrobe;
    hub75Pkg::hub75Bus_t   panelBus;

    // every pixel pair as it was written, indexed like the frame buffer
    hub75Pkg::pixelPair_t model [PIXELS];

    int   cycleCount = 0;
    int   pixelErrors = 0;
    int   latchErrors = 0;
    int   blankErrors = 0;
    int   rowAddrErrors = 0;
    int   otherErrors = 0;

    // monitor state
    logic prevPixClock = 1'b0;
    logic prevLatch = 1'b0;
    logic latchOpen = 1'b0;
    int   initEdges = 0;
    int   scanCol = 0;
    int   scanRow = 0;
    int   rowsDone = 0;

    hub75Top u_hub75Top (
        .clk_in          (clk_in),
        .reset           (reset),
        .pixelWrite      (pixelWrite),
        .pixelWriteStrobe(pixelWriteStrobe),
        .panelBus        (panelBus)
    );

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycleCount <= cycleCount + 1;
    end

    // taps 17 and 14 give a maximal length sequence
    function automatic logic [16:0] lfsrStep(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic checkPixel(input hub75Pkg::pixelPair_t got,
                              input hub75Pkg::pixelPair_t expected, input string where);
        if (got !== expected) begin
            pixelErrors++;
            $display("[FAIL] panelBus.rgb1/rgb2 at %s: got %h expected %h", where, got, expected);
        end
    endtask

    task automatic checkLatch(input logic got, input logic expected, input string where);
        if (got !== expected) begin
            latchErrors++;
            $display("[FAIL] panelBus.latch at %s: got %h expected %h", where, got, expected);
        end
    endtask

    task automatic checkBlank(input logic got, input logic expected, input string where);
        if (got !== expected) begin
            blankErrors++;
            $display("[FAIL] panelBus.blank at %s: got %h expected %h", where, got, expected);
        end
    endtask

    task automatic checkRowAddr(input logic [3:0] got, input logic [3:0] expected,
                                input string where);
        if (got !== expected) begin
            rowAddrErrors++;
            $display("[FAIL] panelBus.rowAddr at %s: got %h expected %h", where, got, expected);
        end
    endtask

    // one rising clock of the register 12 or register 13 write
    task automatic checkInitEdge();
        logic [5:0]           column;
        logic [15:0]          word;
        logic                 bitValue;
        int                   latchFrom;
        hub75Pkg::pixelPair_t expected;
        string                where;
        column = 6'(initEdges % hub75Pkg::PANEL_WIDTH);
        if (initEdges < hub75Pkg::PANEL_WIDTH) begin
            word = hub75Pkg::INIT_REG12_WORD;
            latchFrom = hub75Pkg::PANEL_WIDTH - hub75Pkg::REG12_LATCH_COLUMNS;
        end else begin
            word = hub75Pkg::INIT_REG13_WORD;
            latchFrom = hub75Pkg::PANEL_WIDTH - hub75Pkg::REG13_LATCH_COLUMNS;
        end
        // all six colour lines carry the word bit selected by column mod 16
        bitValue = word[column[3:0]];
        expected = {6{bitValue}};
        where = $sformatf("init edge %0d", initEdges);
        checkPixel({panelBus.rgb1, panelBus.rgb2}, expected, where);
        checkLatch(panelBus.latch, int'(column) >= latchFrom, where);
        checkBlank(panelBus.blank, 1'b1, where);
        checkRowAddr(panelBus.rowAddr, 4'd0, where);
        initEdges++;
    endtask

    // one rising clock while a row pair shifts out
    task automatic checkScanEdge();
        string where;
        where = $sformatf("row pair %0d column %0d", scanRow, scanCol);
        if (scanCol >= hub75Pkg::PANEL_WIDTH) begin
            otherErrors++;
            $display("row pair %0d shifted more than %0d columns without a latch pulse",
                     scanRow, hub75Pkg::PANEL_WIDTH);
        end else begin
            checkPixel({panelBus.rgb1, panelBus.rgb2},
                       model[10'(scanRow * hub75Pkg::PANEL_WIDTH + scanCol)], where);
        end
        checkLatch(panelBus.latch, 1'b0, where);
        checkBlank(panelBus.blank, 1'b0, where);
        scanCol++;
    endtask

    task automatic startLatchPulse();
        string where;
        where = $sformatf("latch of row pair %0d", scanRow);
        // exactly one pulse per row, and only after all its columns
        if (scanCol != hub75Pkg::PANEL_WIDTH) begin
            otherErrors++;
            $display("latch pulse came after %0d columns of row pair %0d instead of %0d",
                     scanCol, scanRow, hub75Pkg::PANEL_WIDTH);
        end
        if (panelBus.pixClock !== 1'b0) begin
            otherErrors++;
            $display("pixel clock was not low during the latch pulse of row pair %0d", scanRow);
        end
        checkBlank(panelBus.blank, 1'b1, where);
        latchOpen = 1'b1;
    endtask

    task automatic endLatchPulse();
        string where;
        where = $sformatf("end of latch of row pair %0d", scanRow);
        // the row address changes together with the falling latch
        checkRowAddr(panelBus.rowAddr, 4'(scanRow), where);
        scanRow = (scanRow + 1) % hub75Pkg::ROW_PAIRS;
        scanCol = 0;
        rowsDone++;
        latchOpen = 1'b0;
    endtask

    // the bus only changes on the rising clock, so the falling edge sees it settled
    always @(negedge clk_in) begin
        if (reset) begin
            prevPixClock = 1'b0;
            prevLatch = 1'b0;
        end else begin
            if (panelBus.pixClock === 1'b1 && prevPixClock === 1'b0) begin
                if (initEdges < INIT_EDGES) begin
                    checkInitEdge();
                end else begin
                    checkScanEdge();
                end
            end
            // init holds latch across edges, so only scan pulses are tracked here
            if (panelBus.latch === 1'b1 && prevLatch === 1'b0 && initEdges >= INIT_EDGES) begin
                startLatchPulse();
            end
            if (panelBus.latch === 1'b0 && prevLatch === 1'b1 && latchOpen) begin
                endLatchPulse();
            end
            prevPixClock = panelBus.pixClock;
            prevLatch = panelBus.latch;
        end
    end

    initial begin
        logic [16:0]          lfsrState;
        logic [5:0]           noise;
        logic [9:0]           index;
        hub75Pkg::pixelPair_t pixel;
        int                   totalErrors;
        reset = 1'b1;
        pixelWrite = '0;
        pixelWriteStrobe = 1'b0;
        lfsrState = 17'd78620;
        repeat (8) @(negedge clk_in);
        reset = 1'b0;

        // row-major writes, one pixel pair per cycle, well ahead of the scan
        for (int i = 0; i < PIXELS; i++) begin
            index = 10'(i);
            noise = '0;
            for (int b = 0; b < 6; b++) begin
                noise = {noise[4:0], lfsrState[0]};
                lfsrState = lfsrStep(lfsrState);
            end
            pixel = ROW_BASE[index[9:6]] ^ noise;
            model[index] = pixel;
            @(negedge clk_in);
            pixelWrite = '{addr: '{rowPair: index[9:6], column: index[5:0]}, data: pixel};
            pixelWriteStrobe = 1'b1;
        end
        @(negedge clk_in);
        pixelWriteStrobe = 1'b0;

        while (rowsDone < ROWS_TO_CHECK && cycleCount < CYCLE_LIMIT) begin
            @(negedge clk_in);
        end
        if (rowsDone < ROWS_TO_CHECK) begin
            otherErrors++;
            $display("timeout after %0d cycles with %0d of %0d row pairs seen",
                     cycleCount, rowsDone, ROWS_TO_CHECK);
        end
        if (initEdges != INIT_EDGES) begin
            otherErrors++;
            $display("saw %0d init clock edges instead of %0d", initEdges, INIT_EDGES);
        end
        totalErrors = pixelErrors + latchErrors + blankErrors + rowAddrErrors + otherErrors;
        $display("errors: pixel %0d, latch %0d, blank %0d, row address %0d, other %0d",
                 pixelErrors, latchErrors, blankErrors, rowAddrErrors, otherErrors);
        if (totalErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
src/hub75Pkg.sv
src/frameBuffer.sv
src/scanDriver.sv
src/panelInitSequencer.sv
src/hub75Top.sv
tests/hub75Tb.sv

// File: run.sh
#!/bin/sh
# builds the HUB75 testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module hub75Tb -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vhub75Tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
